//--- hdl/qeciphy_pkg.sv
`default_nettype none

`include "qeciphy_config.svh"

package qeciphy_pkg;

   // FAW word: marker on top, then sequence number, then spare byte
   typedef struct packed {
      logic [47:0] marker;
      logic [7:0]  seq;
      logic [7:0]  spare;
   } faw_word_t;

   // Data word: 7 payload bytes plus parity byte in the low byte
   typedef struct packed {
      logic [55:0] payload;
      logic [7:0]  parity;
   } data_word_t;

   // Same 64 bits, read as FAW or as data
   typedef union packed {
      faw_word_t  faw;
      data_word_t data;
   } frame_word_u;

   // True when the marker field holds the alignment pattern
   function automatic logic is_faw(input logic [63:0] word);
      frame_word_u w;
      w = word;
      return (w.faw.marker == `QECIPHY_FAW_PATTERN);
   endfunction

   // XOR of the seven payload bytes
   function automatic logic [7:0] payload_parity(input logic [55:0] payload);
      logic [7:0] acc;
      acc = '0;
      for (int i = 0; i < 7; i++) begin
         acc ^= payload[i*8 +: 8];
      end
      return acc;
   endfunction

endpackage

`default_nettype wire

//--- hdl/qeciphy_rx_32b_to_64b.sv
`timescale 1ns/1ps
`default_nettype none

module qeciphy_rx_32b_to_64b (
   input  logic        clk_2x_i,    // Double-rate capture clock
   input  logic        clk_i,       // Word clock
   input  logic        rst_n_i,
   input  logic [31:0] tdata_32b_i, // Half-word stream, one per clk_2x_i
   output logic [63:0] tdata_64b_o, // Aligned 64-bit words
   output logic        aligned_o    // High once lock is reached
);

   // One-hot lock FSM
   localparam logic [2:0] ST_SEARCH  = 3'b001;
   localparam logic [2:0] ST_CONFIRM = 3'b010;
   localparam logic [2:0] ST_DONE    = 3'b100;

   logic [2:0]  state;
   logic [2:0]  state_nxt;

   logic [31:0] half_q;      // Previous half-word
   logic [63:0] pair_2x;     // {current, previous} half-words
   logic [63:0] pair_2x_q;   // Same pair one clk_2x_i later
   logic [63:0] opt_64b [2]; // Both candidate alignments in clk_i domain
   logic [63:0] word_q;      // Selected word

   logic        option;      // Chosen alignment
   logic [1:0]  faw_hit_q;   // FAW seen per option
   logic [7:0]  confirm_cnt; // Cycles spent in confirm
   logic        timeout;

   // ==================================================
   // Half-word capture (clk_2x_i)
   // ==================================================

   always_ff @(posedge clk_2x_i) begin
      half_q    <= tdata_32b_i;
      pair_2x_q <= pair_2x;  // Shifts the pairing by one half-word
   end

   assign pair_2x = {tdata_32b_i, half_q};

   // ==================================================
   // Candidate words and FAW search (clk_i)
   // ==================================================

   // Sampled on the shared edge of both clocks
   always_ff @(posedge clk_i) begin
      opt_64b[0] <= pair_2x;
      opt_64b[1] <= pair_2x_q;
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         faw_hit_q <= 2'b00;
      end else begin
         faw_hit_q[0] <= qeciphy_pkg::is_faw(opt_64b[0]);
         faw_hit_q[1] <= qeciphy_pkg::is_faw(opt_64b[1]);
      end
   end

   // Option is latched whenever search finds a marker
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         option <= 1'b0;
      end else if (state[0] && (|faw_hit_q)) begin
         option <= ~faw_hit_q[0];  // Prefer option 0 when both match
      end
   end

   // Confirm window, restart search after 128 cycles
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         confirm_cnt <= 8'd0;
      end else if (state[1]) begin
         confirm_cnt <= confirm_cnt + 8'd1;
      end else begin
         confirm_cnt <= 8'd0;
      end
   end

   assign timeout = confirm_cnt[7];

   // ==================================================
   // Lock FSM
   // ==================================================

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state <= ST_SEARCH;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      case (state)
         ST_SEARCH: begin
            state_nxt = (|faw_hit_q) ? ST_CONFIRM : ST_SEARCH;
         end
         ST_CONFIRM: begin
            if (timeout) begin
               state_nxt = ST_SEARCH;   // Marker lost, false lock
            end else if (faw_hit_q[option]) begin
               state_nxt = ST_DONE;     // Seen twice on the same option
            end else begin
               state_nxt = ST_CONFIRM;
            end
         end
         ST_DONE: state_nxt = ST_DONE;  // Lock is held
         default: state_nxt = ST_SEARCH;
      endcase
   end

   // Output word lines up with faw_hit_q
   always_ff @(posedge clk_i) begin
      word_q <= opt_64b[option];
   end

   assign tdata_64b_o = word_q;
   assign aligned_o   = state[2];

endmodule

`default_nettype wire

//--- hdl/qeciphy_rx_frame_track.sv
`timescale 1ns/1ps
`default_nettype none

`include "qeciphy_config.svh"

module qeciphy_rx_frame_track (
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   input  qeciphy_pkg::frame_word_u word_i,
   input  logic                     faw_stb_i,
   input  logic                     data_stb_i,
   input  logic                     parity_err_i,
   output logic [55:0]              payload_o,
   output logic                     data_stb_o,
   output logic                     parity_err_o,
   output logic                     frame_err_o,  // FAW off boundary, or missing
   output logic                     seq_err_o     // Sequence number jumped
);

   localparam int FRAME_WORDS = `QECIPHY_FRAME_WORDS;
   localparam int IDX_W       = $clog2(FRAME_WORDS);

   logic [IDX_W-1:0] word_idx;    // Position of the last word in its frame
   logic             synced;      // First FAW after lock seen
   logic [7:0]       last_seq;
   logic [7:0]       seq_exp;     // Wraps at 256
   logic             at_boundary; // Next word should be an FAW

   assign at_boundary = (word_idx == IDX_W'(FRAME_WORDS - 1));
   assign seq_exp     = last_seq + 8'd1;

   // ==================================================
   // Frame position and sequence tracking
   // ==================================================

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         word_idx <= '0;
         synced   <= 1'b0;
      end else if (faw_stb_i) begin
         word_idx <= '0;    // FAW restarts the frame
         synced   <= 1'b1;
      end else if (data_stb_i) begin
         word_idx <= at_boundary ? '0 : word_idx + 1'b1;  // Keep period on a missing FAW
      end
   end

   always_ff @(posedge clk_i) begin
      if (faw_stb_i) begin
         last_seq <= word_i.faw.seq;
      end
   end

   // ==================================================
   // Stage register
   // ==================================================

   always_ff @(posedge clk_i) begin
      payload_o <= word_i.data.payload;
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         data_stb_o   <= 1'b0;
         parity_err_o <= 1'b0;
         frame_err_o  <= 1'b0;
         seq_err_o    <= 1'b0;
      end else begin
         data_stb_o   <= data_stb_i;
         parity_err_o <= parity_err_i;
         frame_err_o  <= synced & ((faw_stb_i & ~at_boundary) | (data_stb_i & at_boundary));
         seq_err_o    <= synced & faw_stb_i & (word_i.faw.seq != seq_exp);
      end
   end

endmodule

`default_nettype wire

//--- hdl/qeciphy_rx_payload_out.sv
`timescale 1ns/1ps
`default_nettype none

`include "qeciphy_config.svh"

module qeciphy_rx_payload_out (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic [55:0]               payload_i,
   input  logic                      data_stb_i,
   input  logic                      parity_err_i,
   input  logic                      frame_err_i,
   input  logic                      seq_err_i,
   output logic [55:0]               payload_o,
   output logic                      payload_valid_o,
   output logic [`QECIPHY_CNT_W-1:0] parity_err_cnt_o,
   output logic [`QECIPHY_CNT_W-1:0] frame_err_cnt_o,
   output logic [`QECIPHY_CNT_W-1:0] seq_err_cnt_o
);

   logic [2:0]                err_stb;     // seq, frame, parity
   logic [`QECIPHY_CNT_W-1:0] err_cnt [3];

   assign err_stb = {seq_err_i, frame_err_i, parity_err_i};

   always_ff @(posedge clk_i) begin
      if (data_stb_i) begin
         payload_o <= payload_i;  // Held between valid words
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         payload_valid_o <= 1'b0;
         for (int i = 0; i < 3; i++) begin
            err_cnt[i] <= '0;
         end
      end else begin
         payload_valid_o <= data_stb_i;
         for (int i = 0; i < 3; i++) begin
            if (err_stb[i] && !(&err_cnt[i])) begin
               err_cnt[i] <= err_cnt[i] + 1'b1;  // Stops at all ones
            end
         end
      end
   end

   assign parity_err_cnt_o = err_cnt[0];
   assign frame_err_cnt_o  = err_cnt[1];
   assign seq_err_cnt_o    = err_cnt[2];

endmodule

`default_nettype wire

//--- hdl/qeciphy_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "qeciphy_config.svh"

module qeciphy_rx_top (
   input  logic                      clk_2x_i,
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic [31:0]               tdata_32b_i,
   output logic [55:0]               payload_o,
   output logic                      payload_valid_o,
   output logic                      aligned_o,
   output logic [`QECIPHY_CNT_W-1:0] parity_err_cnt_o,
   output logic [`QECIPHY_CNT_W-1:0] frame_err_cnt_o,
   output logic [`QECIPHY_CNT_W-1:0] seq_err_cnt_o
);

   logic [63:0]              tdata_64b;       // Gearbox to decode
   logic                     aligned;
   qeciphy_pkg::frame_word_u word_q;          // Decode to execute
   logic                     faw_stb;
   logic                     data_stb;
   logic                     parity_err_stb;
   logic [55:0]              trk_payload;     // Execute to result
   logic                     trk_data_stb;
   logic                     trk_parity_err;
   logic                     frame_err_stb;
   logic                     seq_err_stb;

   qeciphy_rx_32b_to_64b u_gearbox (
      .clk_2x_i    (clk_2x_i),
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .tdata_32b_i (tdata_32b_i),
      .tdata_64b_o (tdata_64b),
      .aligned_o   (aligned)
   );

   qeciphy_rx_word_decode u_decode (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .aligned_i    (aligned),
      .word_i       (tdata_64b),
      .word_o       (word_q),
      .faw_stb_o    (faw_stb),
      .data_stb_o   (data_stb),
      .parity_err_o (parity_err_stb)
   );

   qeciphy_rx_frame_track u_track (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .word_i       (word_q),
      .faw_stb_i    (faw_stb),
      .data_stb_i   (data_stb),
      .parity_err_i (parity_err_stb),
      .payload_o    (trk_payload),
      .data_stb_o   (trk_data_stb),
      .parity_err_o (trk_parity_err),
      .frame_err_o  (frame_err_stb),
      .seq_err_o    (seq_err_stb)
   );

   qeciphy_rx_payload_out u_result (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .payload_i        (trk_payload),
      .data_stb_i       (trk_data_stb),
      .parity_err_i     (trk_parity_err),
      .frame_err_i      (frame_err_stb),
      .seq_err_i        (seq_err_stb),
      .payload_o        (payload_o),
      .payload_valid_o  (payload_valid_o),
      .parity_err_cnt_o (parity_err_cnt_o),
      .frame_err_cnt_o  (frame_err_cnt_o),
      .seq_err_cnt_o    (seq_err_cnt_o)
   );

   assign aligned_o = aligned;  // Lock status straight from the gearbox

endmodule

`default_nettype wire

//--- hdl/qeciphy_rx_word_decode.sv
`timescale 1ns/1ps
`default_nettype none

module qeciphy_rx_word_decode (
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   input  logic                     aligned_i,   // Gearbox lock
   input  logic [63:0]              word_i,      // Aligned word from gearbox
   output qeciphy_pkg::frame_word_u word_o,      // Word, one cycle later
   output logic                     faw_stb_o,
   output logic                     data_stb_o,
   output logic                     parity_err_o
);

   qeciphy_pkg::frame_word_u word_in;
   logic                     faw_hit;
   logic                     parity_bad;

   assign word_in    = word_i;
   assign faw_hit    = qeciphy_pkg::is_faw(word_i);
   // Only meaningful on the data view
   assign parity_bad = (word_in.data.parity !=
                        qeciphy_pkg::payload_parity(word_in.data.payload));

   always_ff @(posedge clk_i) begin
      word_o <= word_in;
   end

   // Nothing leaves this stage before lock
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         faw_stb_o    <= 1'b0;
         data_stb_o   <= 1'b0;
         parity_err_o <= 1'b0;
      end else begin
         faw_stb_o    <= aligned_i & faw_hit;
         data_stb_o   <= aligned_i & ~faw_hit;
         parity_err_o <= aligned_i & ~faw_hit & parity_bad;
      end
   end

endmodule

`default_nettype wire

//--- include/qeciphy_config.svh
`ifndef QECIPHY_CONFIG_SVH
`define QECIPHY_CONFIG_SVH

// Alignment marker, top 48 bits of every FAW word
`define QECIPHY_FAW_PATTERN 48'hF628_2F6A_C35A

// Words per frame, FAW word included
`define QECIPHY_FRAME_WORDS 16

// Width of the saturating error counters
`define QECIPHY_CNT_W 16

`endif

//--- qeciphy_rx.f
+incdir+include
hdl/qeciphy_pkg.sv
hdl/qeciphy_rx_32b_to_64b.sv
hdl/qeciphy_rx_word_decode.sv
hdl/qeciphy_rx_frame_track.sv
hdl/qeciphy_rx_payload_out.sv
hdl/qeciphy_rx_top.sv
verif/qeciphy_rx_props.sv
verif/qeciphy_rx_checker.sv
verif/tb_qeciphy_rx.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the receive path testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f qeciphy_rx.f \
   --top-module tb_qeciphy_rx -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Build failed, see build.log"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
   exit 1
fi
exit 0

//--- verif/qeciphy_rx_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "qeciphy_config.svh"

module qeciphy_rx_checker (
   input logic        clk_i,
   input logic        rst_n_i,
   input logic        aligned_i,
   input logic [55:0] payload_i,
   input logic        payload_valid_i
);

   logic [55:0] exp_payload [$];  // Sent data payloads, oldest first
   bit          exp_bad [$];      // Parity byte was corrupted
   int          err_cnt;
   int          pushed_cnt;
   int          popped_cnt;       // Compared or discarded
   int          bad_cnt;          // Corrupted words delivered after first match
   bit          matched;

   initial begin
      err_cnt = 0;
   end

   task automatic push_expected(input logic [55:0] payload, input bit bad);
      exp_payload.push_back(payload);
      exp_bad.push_back(bad);
      pushed_cnt++;
   endtask

   // Start of a pass, error count kept
   task automatic clear();
      exp_payload.delete();
      exp_bad.delete();
      pushed_cnt = 0;
      popped_cnt = 0;
      bad_cnt    = 0;
      matched    = 0;
   endtask

   task automatic report_fail(input string msg);
      $display("%0t: %s", $time, msg);
      err_cnt++;
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("FAILED %0t %s: got %0d expected %0d", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   // ==================================================
   // Payload comparison
   // ==================================================

   always @(posedge clk_i) begin
      int k;
      if (rst_n_i && payload_valid_i) begin
         if (!aligned_i) report_fail("payload_valid_o high before aligned_o");
         if (payload_i[55:8] == `QECIPHY_FAW_PATTERN) report_fail("FAW word delivered as payload");
         if (!matched) begin
            k = -1;
            for (int i = 0; i < exp_payload.size(); i++) begin
               if (k < 0 && exp_payload[i] == payload_i) k = i;   // Earliest hit
            end
            if (k < 0) begin
               report_fail("first payload after lock matches no sent data word");
            end else begin
               for (int j = 0; j < k; j++) begin
                  void'(exp_payload.pop_front());   // Words lost before lock
                  void'(exp_bad.pop_front());
                  popped_cnt++;
               end
               matched = 1;
            end
         end
         if (matched) begin
            if (exp_payload.size() == 0) begin
               report_fail("payload delivered with no data word outstanding");
            end else begin
               if (exp_payload[0] != payload_i) begin
                  $display("FAILED %0t payload_o: got %h expected %h",
                           $time, payload_i, exp_payload[0]);
                  err_cnt++;
               end
               if (exp_bad[0]) bad_cnt++;
               void'(exp_payload.pop_front());
               void'(exp_bad.pop_front());
               popped_cnt++;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- verif/qeciphy_rx_props.sv
`timescale 1ns/1ps
`default_nettype none

module qeciphy_rx_props (
   input logic        clk_i,
   input logic        rst_n_i,
   input logic        aligned_i,
   input logic [63:0] word_i,      // Gearbox word at the decode input
   input logic        faw_stb_i,
   input logic        data_stb_i,
   input logic        parity_err_i
);

   // Lock is taken on an FAW of the selected option
   a_lock_word : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $rose(aligned_i) |-> qeciphy_pkg::is_faw($past(word_i)))
      else $error("aligned rose without an FAW word on the decode input");

   a_stb_gated : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !aligned_i |-> !(faw_stb_i || data_stb_i || parity_err_i))   // Quiet before lock
      else $error("decode strobe high while aligned is low");

   a_lock_held : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      aligned_i |=> aligned_i)   // Lock is never dropped
      else $error("aligned fell after lock");

endmodule

bind qeciphy_rx_word_decode qeciphy_rx_props u_props (
   .clk_i        (clk_i),
   .rst_n_i      (rst_n_i),
   .aligned_i    (aligned_i),
   .word_i       (word_i),
   .faw_stb_i    (faw_stb_o),
   .data_stb_i   (data_stb_o),
   .parity_err_i (parity_err_o)
);

`default_nettype wire

//--- verif/tb_qeciphy_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "qeciphy_config.svh"

module tb_qeciphy_rx;

   logic                      clk_2x_i;
   logic                      clk_i;
   logic                      rst_n_i;
   logic [31:0]               tdata_32b_i;
   logic [55:0]               payload_o;
   logic                      payload_valid_o;
   logic                      aligned_o;
   logic [`QECIPHY_CNT_W-1:0] parity_err_cnt_o;
   logic [`QECIPHY_CNT_W-1:0] frame_err_cnt_o;
   logic [`QECIPHY_CNT_W-1:0] seq_err_cnt_o;

   integer seed;

   qeciphy_rx_top UUT (
      .clk_2x_i         (clk_2x_i),
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .tdata_32b_i      (tdata_32b_i),
      .payload_o        (payload_o),
      .payload_valid_o  (payload_valid_o),
      .aligned_o        (aligned_o),
      .parity_err_cnt_o (parity_err_cnt_o),
      .frame_err_cnt_o  (frame_err_cnt_o),
      .seq_err_cnt_o    (seq_err_cnt_o)
   );

   qeciphy_rx_checker u_checker (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .aligned_i       (aligned_o),
      .payload_i       (payload_o),
      .payload_valid_i (payload_valid_o)
   );

   // Rising edges of both clocks coincide
   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   initial begin
      clk_2x_i = 1'b1;
      forever #5 clk_2x_i = ~clk_2x_i;
   end

   // ==================================================
   // Stimulus
   // ==================================================

   function automatic logic [7:0] xor_bytes(input logic [55:0] p);
      logic [7:0] x;
      x = 8'h00;
      for (int i = 0; i < 56; i += 8) x = x ^ p[i +: 8];
      return x;
   endfunction

   task automatic send_half(input logic [31:0] h);
      @(negedge clk_2x_i);
      tdata_32b_i = h;
   endtask

   // Low half first, so it lands in the low half of the word
   task automatic send_word(input logic [63:0] w);
      send_half(w[31:0]);
      send_half(w[63:32]);
   endtask

   task automatic send_frame(input logic [7:0] seq, input int n_data, input bit corrupt_en);
      logic [63:0] r;
      logic [7:0]  par;
      bit          bad;
      send_word({`QECIPHY_FAW_PATTERN, seq, 8'h00});
      for (int i = 0; i < n_data; i++) begin
         r   = {$random(seed), $random(seed)};
         bad = corrupt_en && (($random(seed) & 15) == 0);  // About 1 in 16
         par = xor_bytes(r[55:0]) ^ (bad ? 8'h5A : 8'h00);
         u_checker.push_expected(r[55:0], bad);
         send_word({r[55:0], par});
      end
   endtask

   task automatic run_pass(input bit odd);
      int n_fill;
      int target;
      int extra;
      rst_n_i = 1'b0;
      u_checker.clear();
      repeat (10) @(posedge clk_i);
      @(negedge clk_2x_i);
      rst_n_i = 1'b1;
      n_fill = 2 * ($unsigned($random(seed)) % 8) + 4 + (odd ? 1 : 0);  // Picks the option
      for (int i = 0; i < n_fill; i++) send_half($random(seed));
      // Frame 6 skips a number, frame 10 is one word short
      for (int f = 0; f < 14; f++) begin
         send_frame(8'(f + (f >= 6 ? 1 : 0)), (f == 10) ? 14 : 15, 1'b1);
      end
      if (!aligned_o) u_checker.report_fail("aligned_o did not rise within 14 frames");
      target = u_checker.pushed_cnt;
      extra  = 0;
      while (u_checker.popped_cnt < target && extra < 4) begin  // Drain with clean frames
         send_frame(8'(15 + extra), 15, 1'b0);
         extra++;
      end
      if (u_checker.popped_cnt < target) begin
         u_checker.report_fail("sent data words not all delivered within 4 extra frames");
      end
      u_checker.check_count("parity_err_cnt_o", parity_err_cnt_o, u_checker.bad_cnt);
      u_checker.check_count("seq_err_cnt_o", seq_err_cnt_o, 1);
      u_checker.check_count("frame_err_cnt_o", frame_err_cnt_o, 1);
   endtask

   initial begin
      seed        = 32'he18dd31e;
      rst_n_i     = 1'b0;
      tdata_32b_i = 32'h0;
      run_pass(1'b1);
      run_pass(1'b0);
      $display("Closing report: %0d errors, %0d payloads in last pass",
               u_checker.err_cnt, u_checker.popped_cnt);
      if (u_checker.err_cnt == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire
